// ==== Makefile ====
OBJ_DIR = obj_dir
SIM_LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --timescale 1ns/1ps --top-module tb_bp \
		-Mdir $(OBJ_DIR) -f vlog.f

run: compile
	./$(OBJ_DIR)/Vtb_bp | tee $(SIM_LOG)
	grep -q "^sim passed$$" $(SIM_LOG)

clean:
	rm -rf $(OBJ_DIR) $(SIM_LOG)

// ==== bp_defs.svh ====
`ifndef BP_DEFS_SVH
`define BP_DEFS_SVH

// --------------------
// Table geometry
// --------------------

// Global history width, equal to the pattern table index width
`define BP_HIST_BITS      8
`define BP_PHT_ENTRIES    256
`define BP_PC_IDX_LSB     2
`define BP_PC_IDX_MSB     9

// 32 BTB entries indexed by PC[6:2], tag is PC[31:7]
`define BP_BTB_IDX_BITS   5

// Weakly not-taken for pattern counters, weakly gshare for the chooser
`define BP_CTR_RESET      2'b01

// --------------------
// Counter map
// --------------------

`define BP_AXI_ADDR_BITS  8

`define BP_ADDR_UPDATES   8'h00
`define BP_ADDR_MISPRED   8'h04
`define BP_ADDR_GSHARE_OK 8'h08
`define BP_ADDR_LOCAL_OK  8'h0C
`define BP_ADDR_BTB_MISS  8'h10

`endif

// ==== bp_pattern_table.sv ====
`timescale 1ns/1ps
`include "bp_defs.svh"

module bp_pattern_table (
	input  logic                     clk,
	input  logic                     i_rst_n,
	input  logic [`BP_HIST_BITS-1:0] i_rd_idx,
	input  logic [`BP_HIST_BITS-1:0] i_upd_idx,
	input  logic                     i_upd_en,
	input  logic                     i_upd_taken,
	output logic [1:0]               o_rd_ctr,
	output logic [1:0]               o_upd_ctr
);

	logic [1:0] ctr_q [`BP_PHT_ENTRIES];
	logic [1:0] ctr_next;

	// Prediction read and the read at the update index are both combinational
	assign o_rd_ctr  = ctr_q[i_rd_idx];
	assign o_upd_ctr = ctr_q[i_upd_idx];

	// Saturate toward the resolved outcome
	always_comb begin
		ctr_next = o_upd_ctr;
		if (i_upd_taken) begin
			if (o_upd_ctr != 2'b11) begin
				ctr_next = o_upd_ctr + 2'd1;
			end
		end else begin
			if (o_upd_ctr != 2'b00) begin
				ctr_next = o_upd_ctr - 2'd1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			for (int i = 0; i < `BP_PHT_ENTRIES; i++) begin
				ctr_q[i] <= `BP_CTR_RESET;
			end
		end else if (i_upd_en) begin
			ctr_q[i_upd_idx] <= ctr_next;
		end
	end

endmodule

// ==== bp_perf_counters.sv ====
`timescale 1ns/1ps
`include "bp_defs.svh"

module bp_perf_counters (
	input  logic              clk,
	input  logic              i_rst_n,
	input  bp_pkg::bp_event_t i_event,
	input  bp_pkg::axil_req_t i_axil,
	output bp_pkg::axil_rsp_t o_axil
);

	localparam int         NUM_CTRS  = 5;
	localparam logic [2:0] SEL_NONE  = 3'd7;
	localparam logic [1:0] RESP_OKAY = 2'b00;

	bp_pkg::bp_wr_state_e         wr_state_q;
	bp_pkg::bp_wr_state_e         wr_state_d;
	logic [`BP_AXI_ADDR_BITS-1:0] aw_addr_q;
	logic [`BP_AXI_ADDR_BITS-1:0] wr_addr;
	logic [31:0]                  ctr_q [NUM_CTRS];
	logic [NUM_CTRS-1:0]          ctr_inc;
	logic [NUM_CTRS-1:0]          ctr_clr;
	logic [2:0]                   rd_sel;
	logic [2:0]                   wr_sel;
	logic                         aw_ready;
	logic                         w_ready;
	logic                         aw_fire;
	logic                         w_fire;
	logic                         b_fire;
	logic                         ar_fire;
	logic                         r_fire;
	logic                         wr_done;
	logic                         r_valid_q;
	logic [31:0]                  r_data_q;

	function automatic logic [2:0] ctr_sel(input logic [`BP_AXI_ADDR_BITS-1:0] addr);
		case (addr)
			`BP_ADDR_UPDATES:   ctr_sel = 3'd0;
			`BP_ADDR_MISPRED:   ctr_sel = 3'd1;
			`BP_ADDR_GSHARE_OK: ctr_sel = 3'd2;
			`BP_ADDR_LOCAL_OK:  ctr_sel = 3'd3;
			`BP_ADDR_BTB_MISS:  ctr_sel = 3'd4;
			default:            ctr_sel = SEL_NONE;
		endcase
	endfunction

	// --------------------
	// Write channel
	// --------------------

	assign aw_ready = (wr_state_q == bp_pkg::WR_IDLE) || (wr_state_q == bp_pkg::WR_HAVE_W);
	assign w_ready  = (wr_state_q == bp_pkg::WR_IDLE) || (wr_state_q == bp_pkg::WR_HAVE_AW);
	assign aw_fire  = i_axil.aw_valid && aw_ready;
	assign w_fire   = i_axil.w_valid && w_ready;
	assign b_fire   = (wr_state_q == bp_pkg::WR_RESP) && i_axil.b_ready;

	always_comb begin
		wr_state_d = wr_state_q;
		wr_done    = 1'b0;
		case (wr_state_q)
			bp_pkg::WR_IDLE: begin
				if (aw_fire && w_fire) begin
					wr_state_d = bp_pkg::WR_RESP;
					wr_done    = 1'b1;
				end else if (aw_fire) begin
					wr_state_d = bp_pkg::WR_HAVE_AW;
				end else if (w_fire) begin
					wr_state_d = bp_pkg::WR_HAVE_W;
				end
			end
			bp_pkg::WR_HAVE_AW: begin
				if (w_fire) begin
					wr_state_d = bp_pkg::WR_RESP;
					wr_done    = 1'b1;
				end
			end
			bp_pkg::WR_HAVE_W: begin
				if (aw_fire) begin
					wr_state_d = bp_pkg::WR_RESP;
					wr_done    = 1'b1;
				end
			end
			default: begin
				if (b_fire) begin
					wr_state_d = bp_pkg::WR_IDLE;
				end
			end
		endcase
	end

	// The address is live on the bus unless AW was taken earlier
	assign wr_addr = (wr_state_q == bp_pkg::WR_HAVE_AW) ? aw_addr_q : i_axil.aw_addr;
	assign wr_sel  = ctr_sel(wr_addr);

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			wr_state_q <= bp_pkg::WR_IDLE;
		end else begin
			wr_state_q <= wr_state_d;
		end
	end

	always_ff @(posedge clk) begin
		if (aw_fire) begin
			aw_addr_q <= i_axil.aw_addr;
		end
	end

	// --------------------
	// Counters
	// --------------------

	assign ctr_inc = {i_event.btb_miss, i_event.local_ok, i_event.gshare_ok,
		i_event.mispred, i_event.updates};

	always_comb begin
		for (int i = 0; i < NUM_CTRS; i++) begin
			ctr_clr[i] = wr_done && (wr_sel == 3'(i));
		end
	end

	// A clear takes priority over an increment in the same cycle
	always_ff @(posedge clk) begin
		for (int i = 0; i < NUM_CTRS; i++) begin
			if (!i_rst_n || ctr_clr[i]) begin
				ctr_q[i] <= '0;
			end else if (ctr_inc[i]) begin
				ctr_q[i] <= ctr_q[i] + 32'd1;
			end
		end
	end

	// --------------------
	// Read channel
	// --------------------

	assign rd_sel  = ctr_sel(i_axil.ar_addr);
	assign ar_fire = i_axil.ar_valid && !r_valid_q;
	assign r_fire  = r_valid_q && i_axil.r_ready;

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			r_valid_q <= 1'b0;
		end else if (ar_fire) begin
			r_valid_q <= 1'b1;
		end else if (r_fire) begin
			r_valid_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (ar_fire) begin
			r_data_q <= (rd_sel < NUM_CTRS) ? ctr_q[rd_sel] : 32'd0;
		end
	end

	always_comb begin
		o_axil.aw_ready = aw_ready;
		o_axil.w_ready  = w_ready;
		o_axil.b_valid  = (wr_state_q == bp_pkg::WR_RESP);
		o_axil.b_resp   = RESP_OKAY;
		o_axil.ar_ready = !r_valid_q;
		o_axil.r_valid  = r_valid_q;
		o_axil.r_data   = r_data_q;
		o_axil.r_resp   = RESP_OKAY;
	end

endmodule

// ==== bp_pkg.sv ====
`include "bp_defs.svh"

package bp_pkg;

	typedef struct packed {
		logic        valid;
		logic [31:0] pc;
	} bp_pred_req_t;

	// Provider is 0 for gshare and 1 for local
	typedef struct packed {
		logic        taken;
		logic        btb_hit;
		logic [31:0] target;
		logic        provider;
	} bp_pred_rsp_t;

	typedef struct packed {
		logic        valid;
		logic [31:0] pc;
		logic        taken;
		logic [31:0] target;
		logic        mispredict;
	} bp_update_t;

	// One increment strobe per performance counter
	typedef struct packed {
		logic updates;
		logic mispred;
		logic gshare_ok;
		logic local_ok;
		logic btb_miss;
	} bp_event_t;

	typedef struct packed {
		logic                         aw_valid;
		logic [`BP_AXI_ADDR_BITS-1:0] aw_addr;
		logic                         w_valid;
		logic [31:0]                  w_data;
		logic [3:0]                   w_strb;
		logic                         b_ready;
		logic                         ar_valid;
		logic [`BP_AXI_ADDR_BITS-1:0] ar_addr;
		logic                         r_ready;
	} axil_req_t;

	typedef struct packed {
		logic        aw_ready;
		logic        w_ready;
		logic        b_valid;
		logic [1:0]  b_resp;
		logic        ar_ready;
		logic        r_valid;
		logic [31:0] r_data;
		logic [1:0]  r_resp;
	} axil_rsp_t;

	typedef enum logic [1:0] {
		WR_IDLE,
		WR_HAVE_AW,
		WR_HAVE_W,
		WR_RESP
	} bp_wr_state_e;

endpackage

// ==== bp_target_buffer.sv ====
`timescale 1ns/1ps
`include "bp_defs.svh"

module bp_target_buffer (
	input  logic                 clk,
	input  logic                 i_rst_n,
	input  bp_pkg::bp_pred_req_t i_pred,
	input  bp_pkg::bp_update_t   i_upd,
	output logic                 o_hit,
	output logic [31:0]          o_target,
	output logic                 o_upd_hit
);

	localparam int ENTRIES  = 1 << `BP_BTB_IDX_BITS;
	localparam int TAG_LSB  = `BP_PC_IDX_LSB + `BP_BTB_IDX_BITS;
	localparam int TAG_BITS = 32 - TAG_LSB;

	logic [ENTRIES-1:0]         valid_q;
	logic [TAG_BITS-1:0]        tag_q [ENTRIES];
	logic [31:0]                target_q [ENTRIES];
	logic [`BP_BTB_IDX_BITS-1:0] pred_idx;
	logic [`BP_BTB_IDX_BITS-1:0] upd_idx;
	logic [TAG_BITS-1:0]        pred_tag;
	logic [TAG_BITS-1:0]        upd_tag;
	logic                       fill;

	assign pred_idx = i_pred.pc[TAG_LSB-1:`BP_PC_IDX_LSB];
	assign pred_tag = i_pred.pc[31:TAG_LSB];
	assign upd_idx  = i_upd.pc[TAG_LSB-1:`BP_PC_IDX_LSB];
	assign upd_tag  = i_upd.pc[31:TAG_LSB];

	// --------------------
	// Lookups
	// --------------------

	assign o_hit     = i_pred.valid && valid_q[pred_idx] && (tag_q[pred_idx] == pred_tag);
	assign o_target  = target_q[pred_idx];

	// Second lookup at the update PC, used for the miss counter
	assign o_upd_hit = valid_q[upd_idx] && (tag_q[upd_idx] == upd_tag);

	// --------------------
	// Fill
	// --------------------

	assign fill = i_upd.valid && i_upd.taken;

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			valid_q <= '0;
		end else if (fill) begin
			valid_q[upd_idx] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (fill) begin
			tag_q[upd_idx]    <= upd_tag;
			target_q[upd_idx] <= i_upd.target;
		end
	end

endmodule

// ==== bp_top.sv ====
`timescale 1ns/1ps

module bp_top (
	input  logic                 clk,
	input  logic                 i_rst_n,
	input  bp_pkg::bp_pred_req_t i_pred,
	input  bp_pkg::bp_update_t   i_upd,
	input  bp_pkg::axil_req_t    i_axil,
	output bp_pkg::bp_pred_rsp_t o_pred,
	output bp_pkg::axil_rsp_t    o_axil
);

	logic              btb_hit;
	logic [31:0]       btb_target;
	logic              btb_upd_hit;
	bp_pkg::bp_event_t events;

	bp_tournament u_tournament (
		.clk,
		.i_rst_n,
		.i_pred,
		.i_upd,
		.i_btb_hit     (btb_hit),
		.i_btb_target  (btb_target),
		.i_btb_upd_hit (btb_upd_hit),
		.o_pred,
		.o_event       (events)
	);

	bp_target_buffer u_btb (
		.clk,
		.i_rst_n,
		.i_pred,
		.i_upd,
		.o_hit     (btb_hit),
		.o_target  (btb_target),
		.o_upd_hit (btb_upd_hit)
	);

	// Counter block sees the same update cycle as the tables
	bp_perf_counters u_counters (
		.clk,
		.i_rst_n,
		.i_event (events),
		.i_axil,
		.o_axil
	);

endmodule

// ==== bp_tournament.sv ====
`timescale 1ns/1ps
`include "bp_defs.svh"

module bp_tournament (
	input  logic                 clk,
	input  logic                 i_rst_n,
	input  bp_pkg::bp_pred_req_t i_pred,
	input  bp_pkg::bp_update_t   i_upd,
	input  logic                 i_btb_hit,
	input  logic [31:0]          i_btb_target,
	input  logic                 i_btb_upd_hit,
	output bp_pkg::bp_pred_rsp_t o_pred,
	output bp_pkg::bp_event_t    o_event
);

	logic [`BP_HIST_BITS-1:0] ghist_q;
	logic [1:0]               chooser_q;
	logic [`BP_HIST_BITS-1:0] pred_pc_idx;
	logic [`BP_HIST_BITS-1:0] upd_pc_idx;
	logic [`BP_HIST_BITS-1:0] gs_rd_idx;
	logic [`BP_HIST_BITS-1:0] gs_upd_idx;
	logic [1:0]               gs_rd_ctr;
	logic [1:0]               gs_upd_ctr;
	logic [1:0]               lc_rd_ctr;
	logic [1:0]               lc_upd_ctr;
	logic [1:0]               sel_ctr;
	logic                     gs_ok;
	logic                     lc_ok;

	assign pred_pc_idx = i_pred.pc[`BP_PC_IDX_MSB:`BP_PC_IDX_LSB];
	assign upd_pc_idx  = i_upd.pc[`BP_PC_IDX_MSB:`BP_PC_IDX_LSB];

	// Gshare hashes the current history into both indices
	assign gs_rd_idx  = ghist_q ^ pred_pc_idx;
	assign gs_upd_idx = ghist_q ^ upd_pc_idx;

	bp_pattern_table u_gshare (
		.clk,
		.i_rst_n,
		.i_rd_idx    (gs_rd_idx),
		.i_upd_idx   (gs_upd_idx),
		.i_upd_en    (i_upd.valid),
		.i_upd_taken (i_upd.taken),
		.o_rd_ctr    (gs_rd_ctr),
		.o_upd_ctr   (gs_upd_ctr)
	);

	bp_pattern_table u_local (
		.clk,
		.i_rst_n,
		.i_rd_idx    (pred_pc_idx),
		.i_upd_idx   (upd_pc_idx),
		.i_upd_en    (i_upd.valid),
		.i_upd_taken (i_upd.taken),
		.o_rd_ctr    (lc_rd_ctr),
		.o_upd_ctr   (lc_upd_ctr)
	);

	// --------------------
	// Prediction
	// --------------------

	assign sel_ctr = chooser_q[1] ? lc_rd_ctr : gs_rd_ctr;

	// Without a BTB entry there is nowhere to redirect, so fall through
	always_comb begin
		o_pred.taken    = sel_ctr[1] && i_btb_hit;
		o_pred.btb_hit  = i_btb_hit;
		o_pred.target   = i_btb_hit ? i_btb_target : i_pred.pc + 32'd4;
		o_pred.provider = chooser_q[1];
	end

	// --------------------
	// Update
	// --------------------

	assign gs_ok = (gs_upd_ctr[1] == i_upd.taken);
	assign lc_ok = (lc_upd_ctr[1] == i_upd.taken);

	always_comb begin
		o_event.updates   = i_upd.valid;
		o_event.mispred   = i_upd.valid && i_upd.mispredict;
		o_event.gshare_ok = i_upd.valid && gs_ok;
		o_event.local_ok  = i_upd.valid && lc_ok;
		o_event.btb_miss  = i_upd.valid && i_upd.taken && !i_btb_upd_hit;
	end

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			ghist_q   <= '0;
			chooser_q <= `BP_CTR_RESET;
		end else if (i_upd.valid) begin
			ghist_q <= {ghist_q[`BP_HIST_BITS-2:0], i_upd.taken};
			// Chooser only moves when exactly one table was right
			if (lc_ok && !gs_ok && chooser_q != 2'b11) begin
				chooser_q <= chooser_q + 2'd1;
			end else if (gs_ok && !lc_ok && chooser_q != 2'b00) begin
				chooser_q <= chooser_q - 2'd1;
			end
		end
	end

endmodule

// ==== tb_bp.sv ====
`timescale 1ns/1ps
`include "bp_defs.svh"

module tb_bp;

	typedef struct packed {
		logic [31:0] pred_pc;
		logic        upd_valid;
		logic [31:0] upd_pc;
		logic        taken;
		logic [31:0] target;
		logic        mispredict;
	} step_t;

	localparam int         WAIT_LIMIT  = 50;
	localparam int         BTB_ENTRIES = 1 << `BP_BTB_IDX_BITS;
	localparam int         TAG_LSB     = `BP_PC_IDX_LSB + `BP_BTB_IDX_BITS;
	localparam logic [1:0] RESP_OKAY   = 2'b00;

	logic                 clk;
	logic                 i_rst_n;
	bp_pkg::bp_pred_req_t i_pred;
	bp_pkg::bp_update_t   i_upd;
	bp_pkg::axil_req_t    i_axil;
	bp_pkg::bp_pred_rsp_t o_pred;
	bp_pkg::axil_rsp_t    o_axil;

	// --------------------
	// Reference model state
	// --------------------
	logic [1:0]               m_gs [`BP_PHT_ENTRIES];
	logic [1:0]               m_lc [`BP_PHT_ENTRIES];
	logic [`BP_HIST_BITS-1:0] m_hist;
	logic [1:0]               m_chooser;
	logic                     m_btb_valid [BTB_ENTRIES];
	logic [31:0]              m_btb_pc [BTB_ENTRIES];
	logic [31:0]              m_btb_target [BTB_ENTRIES];
	logic [31:0]              m_cnt [5];

	step_t steps [$];

	bp_top dut (
		.clk,
		.i_rst_n,
		.i_pred,
		.i_upd,
		.i_axil,
		.o_pred,
		.o_axil
	);

	always #10 clk = ~clk;

	task automatic stop_with_failure();
		$display("sim failed");
		$fatal(1, "Simulation stopped on the first error");
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout: the %s handshake never completed", what);
		stop_with_failure();
	endtask

	task automatic check_pred(input bp_pkg::bp_pred_rsp_t got, input bp_pkg::bp_pred_rsp_t exp,
		input string what);
		if (got !== exp) begin
			$display("[FAIL] %0t %s: got taken=%0b hit=%0b target=%h provider=%0b", $time, what,
				got.taken, got.btb_hit, got.target, got.provider);
			$display("[FAIL] %0t %s: expected taken=%0b hit=%0b target=%h provider=%0b", $time,
				what, exp.taken, exp.btb_hit, exp.target, exp.provider);
			stop_with_failure();
		end
	endtask

	task automatic check_axil_data(input logic [31:0] got_data, input logic [1:0] got_resp,
		input logic [31:0] exp_data, input logic [1:0] exp_resp, input string what);
		if (got_data !== exp_data || got_resp !== exp_resp) begin
			$display("[FAIL] %0t %s: got data=%h resp=%b, expected data=%h resp=%b", $time, what,
				got_data, got_resp, exp_data, exp_resp);
			stop_with_failure();
		end
	endtask

	function automatic logic [`BP_HIST_BITS-1:0] pc_index(input logic [31:0] pc);
		return pc[`BP_PC_IDX_MSB:`BP_PC_IDX_LSB];
	endfunction

	function automatic logic [`BP_BTB_IDX_BITS-1:0] btb_index(input logic [31:0] pc);
		return pc[TAG_LSB-1:`BP_PC_IDX_LSB];
	endfunction

	function automatic logic btb_lookup(input logic [31:0] pc);
		logic [`BP_BTB_IDX_BITS-1:0] idx;
		idx = btb_index(pc);
		return m_btb_valid[idx] && (m_btb_pc[idx][31:TAG_LSB] == pc[31:TAG_LSB]);
	endfunction

	function automatic logic [1:0] saturate(input logic [1:0] ctr, input logic taken);
		if (taken) begin
			return (ctr == 2'b11) ? ctr : ctr + 2'd1;
		end
		return (ctr == 2'b00) ? ctr : ctr - 2'd1;
	endfunction

	function automatic int ctr_slot(input logic [7:0] addr);
		case (addr)
			`BP_ADDR_UPDATES:   return 0;
			`BP_ADDR_MISPRED:   return 1;
			`BP_ADDR_GSHARE_OK: return 2;
			`BP_ADDR_LOCAL_OK:  return 3;
			`BP_ADDR_BTB_MISS:  return 4;
			default:            return -1;
		endcase
	endfunction

	function automatic logic [7:0] ctr_addr(input int slot);
		case (slot)
			0:       return `BP_ADDR_UPDATES;
			1:       return `BP_ADDR_MISPRED;
			2:       return `BP_ADDR_GSHARE_OK;
			3:       return `BP_ADDR_LOCAL_OK;
			default: return `BP_ADDR_BTB_MISS;
		endcase
	endfunction

	function automatic bp_pkg::bp_pred_rsp_t model_pred(input logic [31:0] pc);
		bp_pkg::bp_pred_rsp_t rsp;
		logic [1:0]           ctr;
		logic                 hit;
		hit = btb_lookup(pc);
		ctr = m_chooser[1] ? m_lc[pc_index(pc)] : m_gs[m_hist ^ pc_index(pc)];
		rsp.taken    = hit && ctr[1];
		rsp.btb_hit  = hit;
		rsp.target   = hit ? m_btb_target[btb_index(pc)] : pc + 32'd4;
		rsp.provider = m_chooser[1];
		return rsp;
	endfunction

	task automatic model_reset();
		for (int i = 0; i < `BP_PHT_ENTRIES; i++) begin
			m_gs[i] = `BP_CTR_RESET;
			m_lc[i] = `BP_CTR_RESET;
		end
		for (int i = 0; i < BTB_ENTRIES; i++) begin
			m_btb_valid[i] = 1'b0;
		end
		for (int i = 0; i < 5; i++) begin
			m_cnt[i] = 32'd0;
		end
		m_hist    = '0;
		m_chooser = `BP_CTR_RESET;
	endtask

	// All reads happen against the state before the update edge
	task automatic model_update(input bp_pkg::bp_update_t upd);
		logic [`BP_HIST_BITS-1:0] li;
		logic [`BP_HIST_BITS-1:0] gi;
		logic                     gs_ok;
		logic                     lc_ok;
		if (!upd.valid) begin
			return;
		end
		li    = pc_index(upd.pc);
		gi    = m_hist ^ li;
		gs_ok = (m_gs[gi][1] == upd.taken);
		lc_ok = (m_lc[li][1] == upd.taken);
		m_cnt[0] = m_cnt[0] + 32'd1;
		if (upd.mispredict) m_cnt[1] = m_cnt[1] + 32'd1;
		if (gs_ok) m_cnt[2] = m_cnt[2] + 32'd1;
		if (lc_ok) m_cnt[3] = m_cnt[3] + 32'd1;
		if (upd.taken && !btb_lookup(upd.pc)) m_cnt[4] = m_cnt[4] + 32'd1;
		m_gs[gi] = saturate(m_gs[gi], upd.taken);
		m_lc[li] = saturate(m_lc[li], upd.taken);
		if (lc_ok && !gs_ok && m_chooser != 2'b11) begin
			m_chooser = m_chooser + 2'd1;
		end else if (gs_ok && !lc_ok && m_chooser != 2'b00) begin
			m_chooser = m_chooser - 2'd1;
		end
		m_hist = {m_hist[`BP_HIST_BITS-2:0], upd.taken};
		if (upd.taken) begin
			m_btb_valid[btb_index(upd.pc)]  = 1'b1;
			m_btb_pc[btb_index(upd.pc)]     = upd.pc;
			m_btb_target[btb_index(upd.pc)] = upd.target;
		end
	endtask

	task automatic add_step(input logic [31:0] pred_pc, input logic upd_valid,
		input logic [31:0] upd_pc, input logic taken, input logic [31:0] target,
		input logic mispredict);
		steps.push_back('{pred_pc, upd_valid, upd_pc, taken, target, mispredict});
	endtask

	task automatic run_steps();
		bp_pkg::bp_pred_rsp_t exp;
		foreach (steps[i]) begin
			@(negedge clk);
			i_pred.valid      = 1'b1;
			i_pred.pc         = steps[i].pred_pc;
			i_upd.valid       = steps[i].upd_valid;
			i_upd.pc          = steps[i].upd_pc;
			i_upd.taken       = steps[i].taken;
			i_upd.target      = steps[i].target;
			i_upd.mispredict  = steps[i].mispredict;
			#5;
			exp = model_pred(steps[i].pred_pc);
			check_pred(o_pred, exp, $sformatf("step %0d pc %h", i, steps[i].pred_pc));
			model_update(i_upd);
		end
		@(negedge clk);
		i_upd.valid = 1'b0;
		steps.delete();
	endtask

	task automatic next_cycle_or_timeout(inout int waited, input string what);
		@(negedge clk);
		#1;
		waited++;
		if (waited > WAIT_LIMIT) begin
			report_timeout(what);
		end
	endtask

	task automatic axil_read(input logic [7:0] addr, output logic [31:0] data,
		output logic [1:0] resp);
		int t;
		@(negedge clk);
		i_axil.ar_valid = 1'b1;
		i_axil.ar_addr  = addr;
		t = 0;
		#1;
		while (!o_axil.ar_ready) next_cycle_or_timeout(t, "AR");
		@(negedge clk);
		i_axil.ar_valid = 1'b0;
		i_axil.r_ready  = 1'b1;
		t = 0;
		#1;
		while (!o_axil.r_valid) next_cycle_or_timeout(t, "R");
		data = o_axil.r_data;
		resp = o_axil.r_resp;
		@(negedge clk);
		i_axil.r_ready = 1'b0;
	endtask

	// The update rides along with the second half of the address/data pair
	task automatic axil_write(input logic [7:0] addr, input logic aw_first,
		input bp_pkg::bp_update_t upd);
		int t;
		@(negedge clk);
		i_axil.aw_addr  = addr;
		i_axil.w_data   = 32'hffff_ffff;
		i_axil.w_strb   = 4'hf;
		i_axil.aw_valid = aw_first;
		i_axil.w_valid  = !aw_first;
		t = 0;
		#1;
		while (!(aw_first ? o_axil.aw_ready : o_axil.w_ready)) begin
			next_cycle_or_timeout(t, aw_first ? "AW" : "W");
		end
		@(negedge clk);
		i_axil.aw_valid = !aw_first;
		i_axil.w_valid  = aw_first;
		i_axil.b_ready  = 1'b1;
		i_upd           = upd;
		model_update(upd);
		t = 0;
		#1;
		while (!(aw_first ? o_axil.w_ready : o_axil.aw_ready)) begin
			next_cycle_or_timeout(t, aw_first ? "W" : "AW");
			i_upd.valid = 1'b0;
		end
		if (ctr_slot(addr) >= 0) m_cnt[ctr_slot(addr)] = 32'd0;
		@(negedge clk);
		i_axil.aw_valid = 1'b0;
		i_axil.w_valid  = 1'b0;
		i_upd.valid     = 1'b0;
		t = 0;
		#1;
		while (!o_axil.b_valid) next_cycle_or_timeout(t, "B");
		check_axil_data(32'd0, o_axil.b_resp, 32'd0, RESP_OKAY, "write response");
		@(negedge clk);
		i_axil.b_ready = 1'b0;
	endtask

	task automatic check_counters();
		logic [31:0] data;
		logic [1:0]  resp;
		for (int i = 0; i < 5; i++) begin
			axil_read(ctr_addr(i), data, resp);
			check_axil_data(data, resp, m_cnt[i], RESP_OKAY, $sformatf("counter %0d", i));
		end
		axil_read(8'h14, data, resp);
		check_axil_data(data, resp, 32'd0, RESP_OKAY, "unmapped address");
	endtask

	initial begin
		bp_pkg::bp_pred_rsp_t exp;
		bp_pkg::bp_update_t   upd;
		logic [31:0]          r;
		logic [31:0]          pc_a;
		logic [31:0]          tgt_a;
		void'($urandom(32'hd365_d655));
		clk     = 1'b0;
		i_rst_n = 1'b0;
		i_pred  = '0;
		i_upd   = '0;
		i_axil  = '0;
		model_reset();
		repeat (3) @(posedge clk);
		@(negedge clk);
		i_rst_n = 1'b1;

		// Fresh predictor falls through at every PC
		for (int i = 0; i < 4; i++) begin
			add_step(32'h0000_0100 + 32'(i * 36), 1'b0, 32'd0, 1'b0, 32'd0, 1'b0);
		end
		run_steps();
		@(negedge clk);
		i_pred.pc = 32'h0000_0abc;
		#5;
		exp = '{taken: 1'b0, btb_hit: 1'b0, target: 32'h0000_0ac0, provider: 1'b0};
		check_pred(o_pred, exp, "after reset");
		check_counters();

		// Two taken updates move local to 11 and the chooser to local
		pc_a  = 32'h0000_1040;
		tgt_a = 32'h0000_2000;
		add_step(pc_a, 1'b1, pc_a, 1'b1, tgt_a, 1'b1);
		add_step(pc_a, 1'b1, pc_a, 1'b1, tgt_a, 1'b1);
		run_steps();
		@(negedge clk);
		i_pred.pc = pc_a;
		#5;
		exp = '{taken: 1'b1, btb_hit: 1'b1, target: tgt_a, provider: 1'b1};
		check_pred(o_pred, exp, "trained branch");

		// One branch always taken, another toggling, so the history keeps moving
		for (int i = 0; i < 12; i++) begin
			add_step(32'h0000_1200, 1'b1, 32'h0000_1200, 1'b1, 32'h0000_3000, 1'b0);
			add_step(32'h0000_1300, 1'b1, 32'h0000_1300, i[0], 32'h0000_3400, i[0]);
		end
		run_steps();

		for (int i = 0; i < 200; i++) begin
			r = $urandom;
			add_step(32'h0000_1000 | (r & 32'h0000_03fc), r[31:28] != 4'h0,
				32'h0000_1000 | ($urandom & 32'h0000_03fc), r[11], $urandom & 32'hffff_fffc,
				r[12]);
		end
		run_steps();
		check_counters();

		upd = '{valid: 1'b1, pc: pc_a, taken: 1'b1, target: tgt_a, mispredict: 1'b1};
		axil_write(`BP_ADDR_MISPRED, 1'b1, upd);
		check_counters();
		add_step(pc_a, 1'b1, pc_a, 1'b0, tgt_a, 1'b1);
		add_step(pc_a, 1'b1, pc_a, 1'b1, tgt_a, 1'b1);
		run_steps();
		axil_write(`BP_ADDR_MISPRED, 1'b0, upd);
		check_counters();

		$display("sim passed");
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+.
bp_pkg.sv
bp_pattern_table.sv
bp_target_buffer.sv
bp_tournament.sv
bp_perf_counters.sv
bp_top.sv
tb_bp.sv
